//--- common/db_cfg.svh
`ifndef DB_CFG_SVH
`define DB_CFG_SVH

// Database key width
`define DB_KEY_W 8

// Database value width
`define DB_VALUE_W 16

// Control protocol code widths
`define DB_CMD_W 3
`define DB_STATUS_W 2

`endif

//--- common/db_proto_pkg.sv
`default_nettype none

package db_proto_pkg;

    `include "db_cfg.svh"

    // Request command of the control port
    typedef enum logic [`DB_CMD_W-1:0] {
        CMD_NOP   = 3'd0,
        CMD_GET   = 3'd1,
        CMD_SET   = 3'd2,
        CMD_UNSET = 3'd3,
        CMD_CLEAR = 3'd4
    } db_command_t;

    // Response status returned with ack
    typedef enum logic [`DB_STATUS_W-1:0] {
        STATUS_OK          = 2'd0,
        STATUS_ERROR       = 2'd1,
        STATUS_TIMEOUT     = 2'd2,
        STATUS_UNSPECIFIED = 2'd3
    } db_status_t;

endpackage : db_proto_pkg

`default_nettype wire

//--- common/db_data_pkg.sv
`default_nettype none

package db_data_pkg;

    `include "db_cfg.svh"

    // Database key word
    typedef logic [`DB_KEY_W-1:0] db_key_t;

    // Database value word
    typedef logic [`DB_VALUE_W-1:0] db_value_t;

endpackage : db_data_pkg

`default_nettype wire

//--- logic/db_req_proxy.sv
`timescale 1ns/100ps
`default_nettype none

module db_req_proxy
    import db_proto_pkg::*;
    import db_data_pkg::*;
(
    input  wire         clk,
    input  wire         srst,
    // Upstream (controller side)
    input  wire         i_req,
    input  db_command_t i_command,
    input  db_key_t     i_key,
    input  db_value_t   i_set_value,
    output logic        o_rdy,
    output logic        o_ack,
    output db_status_t  o_status,
    output logic        o_get_valid,
    output db_key_t     o_get_key,
    output db_value_t   o_get_value,
    // Downstream (peripheral side)
    output logic        o_req,
    output db_command_t o_command,
    output db_key_t     o_key,
    output db_value_t   o_set_value,
    input  wire         i_rdy_dn,
    input  wire         i_ack_dn,
    input  db_status_t  i_status_dn,
    input  wire         i_get_valid_dn,
    input  db_key_t     i_get_key_dn,
    input  db_value_t   i_get_value_dn
);

    logic pending;
    logic in_progress;
    logic accept;

    // One open transaction at a time
    assign o_rdy  = !pending && !in_progress;
    assign accept = i_req && o_rdy;

    // Request waits here until downstream takes it
    always_ff @(posedge clk) begin
        if (srst) begin
            pending <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end else if (i_rdy_dn) begin
            pending <= 1'b0;
        end
    end

    // Accepted downstream, waiting for ack
    always_ff @(posedge clk) begin
        if (srst) begin
            in_progress <= 1'b0;
        end else if (pending && i_rdy_dn) begin
            in_progress <= 1'b1;
        end else if (i_ack_dn) begin
            in_progress <= 1'b0;
        end
    end

    assign o_req = pending;

    // Request context, held stable while pending
    always_ff @(posedge clk) begin
        if (accept) begin
            o_command   <= i_command;
            o_key       <= i_key;
            o_set_value <= i_set_value;
        end
    end

    // Response goes straight back
    assign o_ack       = i_ack_dn;
    assign o_status    = i_status_dn;
    assign o_get_valid = i_get_valid_dn;
    assign o_get_key   = i_get_key_dn;
    assign o_get_value = i_get_value_dn;

endmodule : db_req_proxy

`default_nettype wire

//--- arbiter/db_ctrl_mux.sv
`timescale 1ns/100ps
`default_nettype none

module db_ctrl_mux
    import db_proto_pkg::*;
    import db_data_pkg::*;
(
    input  wire         clk,
    input  wire         srst,
    input  wire         i_sel,
    // Input 0
    input  wire         i_req_0,
    input  db_command_t i_command_0,
    input  db_key_t     i_key_0,
    input  db_value_t   i_set_value_0,
    output logic        o_rdy_0,
    output logic        o_ack_0,
    output db_status_t  o_status_0,
    output logic        o_get_valid_0,
    output db_key_t     o_get_key_0,
    output db_value_t   o_get_value_0,
    // Input 1
    input  wire         i_req_1,
    input  db_command_t i_command_1,
    input  db_key_t     i_key_1,
    input  db_value_t   i_set_value_1,
    output logic        o_rdy_1,
    output logic        o_ack_1,
    output db_status_t  o_status_1,
    output logic        o_get_valid_1,
    output db_key_t     o_get_key_1,
    output db_value_t   o_get_value_1,
    // Downstream
    output logic        o_req,
    output db_command_t o_command,
    output db_key_t     o_key,
    output db_value_t   o_set_value,
    input  wire         i_rdy,
    input  wire         i_ack,
    input  db_status_t  i_status,
    input  wire         i_get_valid,
    input  db_key_t     i_get_key,
    input  db_value_t   i_get_value
);

    logic        sel_req;
    db_command_t sel_command;
    db_key_t     sel_key;
    db_value_t   sel_set_value;

    logic        px_rdy;
    logic        px_ack;
    db_status_t  px_status;
    logic        px_get_valid;
    db_key_t     px_get_key;
    db_value_t   px_get_value;

    logic        sel_reg;

    // Steer selected request into the proxy
    assign sel_req       = i_sel ? i_req_1       : i_req_0;
    assign sel_command   = i_sel ? i_command_1   : i_command_0;
    assign sel_key       = i_sel ? i_key_1       : i_key_0;
    assign sel_set_value = i_sel ? i_set_value_1 : i_set_value_0;

    // Unselected input never sees rdy
    assign o_rdy_0 = !i_sel && px_rdy;
    assign o_rdy_1 = i_sel && px_rdy;

    db_req_proxy u_proxy (
        .clk            (clk),
        .srst           (srst),
        .i_req          (sel_req),
        .i_command      (sel_command),
        .i_key          (sel_key),
        .i_set_value    (sel_set_value),
        .o_rdy          (px_rdy),
        .o_ack          (px_ack),
        .o_status       (px_status),
        .o_get_valid    (px_get_valid),
        .o_get_key      (px_get_key),
        .o_get_value    (px_get_value),
        .o_req          (o_req),
        .o_command      (o_command),
        .o_key          (o_key),
        .o_set_value    (o_set_value),
        .i_rdy_dn       (i_rdy),
        .i_ack_dn       (i_ack),
        .i_status_dn    (i_status),
        .i_get_valid_dn (i_get_valid),
        .i_get_key_dn   (i_get_key),
        .i_get_value_dn (i_get_value)
    );

    // Owner of the open transaction
    always_ff @(posedge clk) begin
        if (srst) begin
            sel_reg <= 1'b0;
        end else if (sel_req && px_rdy) begin
            sel_reg <= i_sel;
        end
    end

    // Ack returns only to the owner, one cycle late
    always_ff @(posedge clk) begin
        if (srst) begin
            o_ack_0 <= 1'b0;
            o_ack_1 <= 1'b0;
        end else begin
            o_ack_0 <= px_ack && !sel_reg;
            o_ack_1 <= px_ack && sel_reg;
        end
    end

    // Response fields, aligned with the registered ack
    always_ff @(posedge clk) begin
        o_status_0    <= px_status;
        o_get_valid_0 <= px_get_valid;
        o_get_key_0   <= px_get_key;
        o_get_value_0 <= px_get_value;
        o_status_1    <= px_status;
        o_get_valid_1 <= px_get_valid;
        o_get_key_1   <= px_get_key;
        o_get_value_1 <= px_get_value;
    end

endmodule : db_ctrl_mux

`default_nettype wire

//--- arbiter/db_prio_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module db_prio_arbiter
    import db_proto_pkg::*;
    import db_data_pkg::*;
(
    input  wire         clk,
    input  wire         srst,
    // High-priority controller
    input  wire         i_hi_req,
    input  db_command_t i_hi_command,
    input  db_key_t     i_hi_key,
    input  db_value_t   i_hi_set_value,
    output logic        o_hi_rdy,
    output logic        o_hi_ack,
    output db_status_t  o_hi_status,
    output logic        o_hi_get_valid,
    output db_key_t     o_hi_get_key,
    output db_value_t   o_hi_get_value,
    // Low-priority controller
    input  wire         i_lo_req,
    input  db_command_t i_lo_command,
    input  db_key_t     i_lo_key,
    input  db_value_t   i_lo_set_value,
    output logic        o_lo_rdy,
    output logic        o_lo_ack,
    output db_status_t  o_lo_status,
    output logic        o_lo_get_valid,
    output db_key_t     o_lo_get_key,
    output db_value_t   o_lo_get_value,
    // Peripheral port
    output logic        o_db_req,
    output db_command_t o_db_command,
    output db_key_t     o_db_key,
    output db_value_t   o_db_set_value,
    input  wire         i_db_rdy,
    input  wire         i_db_ack,
    input  db_status_t  i_db_status,
    input  wire         i_db_get_valid,
    input  db_key_t     i_db_get_key,
    input  db_value_t   i_db_get_value
);

    // Hi proxy to mux input 1
    logic        hi_req;
    db_command_t hi_command;
    db_key_t     hi_key;
    db_value_t   hi_set_value;
    logic        hi_rdy;
    logic        hi_ack;
    db_status_t  hi_status;
    logic        hi_get_valid;
    db_key_t     hi_get_key;
    db_value_t   hi_get_value;

    // Lo proxy to mux input 0
    logic        lo_req;
    db_command_t lo_command;
    db_key_t     lo_key;
    db_value_t   lo_set_value;
    logic        lo_rdy;
    logic        lo_ack;
    db_status_t  lo_status;
    logic        lo_get_valid;
    db_key_t     lo_get_key;
    db_value_t   lo_get_value;

    db_req_proxy u_hi_proxy (
        .clk            (clk),
        .srst           (srst),
        .i_req          (i_hi_req),
        .i_command      (i_hi_command),
        .i_key          (i_hi_key),
        .i_set_value    (i_hi_set_value),
        .o_rdy          (o_hi_rdy),
        .o_ack          (o_hi_ack),
        .o_status       (o_hi_status),
        .o_get_valid    (o_hi_get_valid),
        .o_get_key      (o_hi_get_key),
        .o_get_value    (o_hi_get_value),
        .o_req          (hi_req),
        .o_command      (hi_command),
        .o_key          (hi_key),
        .o_set_value    (hi_set_value),
        .i_rdy_dn       (hi_rdy),
        .i_ack_dn       (hi_ack),
        .i_status_dn    (hi_status),
        .i_get_valid_dn (hi_get_valid),
        .i_get_key_dn   (hi_get_key),
        .i_get_value_dn (hi_get_value)
    );

    db_req_proxy u_lo_proxy (
        .clk            (clk),
        .srst           (srst),
        .i_req          (i_lo_req),
        .i_command      (i_lo_command),
        .i_key          (i_lo_key),
        .i_set_value    (i_lo_set_value),
        .o_rdy          (o_lo_rdy),
        .o_ack          (o_lo_ack),
        .o_status       (o_lo_status),
        .o_get_valid    (o_lo_get_valid),
        .o_get_key      (o_lo_get_key),
        .o_get_value    (o_lo_get_value),
        .o_req          (lo_req),
        .o_command      (lo_command),
        .o_key          (lo_key),
        .o_set_value    (lo_set_value),
        .i_rdy_dn       (lo_rdy),
        .i_ack_dn       (lo_ack),
        .i_status_dn    (lo_status),
        .i_get_valid_dn (lo_get_valid),
        .i_get_key_dn   (lo_get_key),
        .i_get_value_dn (lo_get_value)
    );

    // A pending hi request always wins the select
    db_ctrl_mux u_mux (
        .clk           (clk),
        .srst          (srst),
        .i_sel         (hi_req),
        .i_req_0       (lo_req),
        .i_command_0   (lo_command),
        .i_key_0       (lo_key),
        .i_set_value_0 (lo_set_value),
        .o_rdy_0       (lo_rdy),
        .o_ack_0       (lo_ack),
        .o_status_0    (lo_status),
        .o_get_valid_0 (lo_get_valid),
        .o_get_key_0   (lo_get_key),
        .o_get_value_0 (lo_get_value),
        .i_req_1       (hi_req),
        .i_command_1   (hi_command),
        .i_key_1       (hi_key),
        .i_set_value_1 (hi_set_value),
        .o_rdy_1       (hi_rdy),
        .o_ack_1       (hi_ack),
        .o_status_1    (hi_status),
        .o_get_valid_1 (hi_get_valid),
        .o_get_key_1   (hi_get_key),
        .o_get_value_1 (hi_get_value),
        .o_req         (o_db_req),
        .o_command     (o_db_command),
        .o_key         (o_db_key),
        .o_set_value   (o_db_set_value),
        .i_rdy         (i_db_rdy),
        .i_ack         (i_db_ack),
        .i_status      (i_db_status),
        .i_get_valid   (i_db_get_valid),
        .i_get_key     (i_db_get_key),
        .i_get_value   (i_db_get_value)
    );

endmodule : db_prio_arbiter

`default_nettype wire

//--- sim/db_arb_checker.sv
`timescale 1ns/100ps
`default_nettype none

module db_arb_checker
    import db_proto_pkg::*;
    import db_data_pkg::*;
(
    input  wire         clk,
    input  wire         srst,
    // High-priority controller port, as seen on the DUT
    input  wire         i_hi_req,
    input  db_command_t i_hi_command,
    input  db_key_t     i_hi_key,
    input  db_value_t   i_hi_set_value,
    input  wire         i_hi_rdy,
    input  wire         i_hi_ack,
    input  db_status_t  i_hi_status,
    input  wire         i_hi_get_valid,
    input  db_key_t     i_hi_get_key,
    input  db_value_t   i_hi_get_value,
    // Low-priority controller port
    input  wire         i_lo_req,
    input  db_command_t i_lo_command,
    input  db_key_t     i_lo_key,
    input  db_value_t   i_lo_set_value,
    input  wire         i_lo_rdy,
    input  wire         i_lo_ack,
    input  db_status_t  i_lo_status,
    input  wire         i_lo_get_valid,
    input  db_key_t     i_lo_get_key,
    input  db_value_t   i_lo_get_value,
    // Peripheral port
    input  wire         i_db_req,
    input  db_command_t i_db_command,
    input  db_key_t     i_db_key,
    input  db_value_t   i_db_set_value,
    input  wire         i_db_rdy,
    input  wire         i_db_ack,
    output int          o_check_errors,
    output int          o_protocol_errors,
    output int          o_open_count
);

    // Index 1 is the hi port, index 0 the lo port
    logic        req_s [2];
    logic        rdy_s [2];
    logic        ack_s [2];
    logic        acc_s [2];
    db_command_t cmd_s [2];
    db_key_t     key_s [2];
    db_value_t   val_s [2];
    db_status_t  status_s [2];
    logic        get_valid_s [2];
    db_key_t     get_key_s [2];
    db_value_t   get_value_s [2];

    // Per-port transaction record
    bit          open [2];
    bit          waiting [2];
    bit          lone [2];
    int          acc_cyc [2];
    db_command_t rec_cmd [2];
    db_key_t     rec_key [2];
    db_value_t   rec_val [2];

    bit          dn_active;
    bit          dn_accepted;
    int          dn_owner;
    bit          ack_pending;
    int          ack_owner;
    int          ack_due;
    db_status_t  exp_status;
    logic        exp_get_valid;
    db_key_t     exp_get_key;
    db_value_t   exp_get_value;
    bit          prev_req;
    bit          reset_checked;
    int          cycle;
    int          cand;

    assign o_open_count = int'(open[0]) + int'(open[1]);

    function automatic string port_name(input int p);
        return (p == 1) ? "hi" : "lo";
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("CHECK FAILED: %s expected %h actual %h at cycle %0d",
                 name, exp_v, act_v, cycle);
        o_check_errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("Protocol error at cycle %0d: %s", cycle, msg);
        o_protocol_errors++;
    endtask

    initial begin
        o_check_errors    = 0;
        o_protocol_errors = 0;
    end

    // All sampling happens at the rising edge, before the DUT registers update
    always @(posedge clk) begin
        req_s       = '{i_lo_req, i_hi_req};
        rdy_s       = '{i_lo_rdy, i_hi_rdy};
        ack_s       = '{i_lo_ack, i_hi_ack};
        cmd_s       = '{i_lo_command, i_hi_command};
        key_s       = '{i_lo_key, i_hi_key};
        val_s       = '{i_lo_set_value, i_hi_set_value};
        status_s    = '{i_lo_status, i_hi_status};
        get_valid_s = '{i_lo_get_valid, i_hi_get_valid};
        get_key_s   = '{i_lo_get_key, i_hi_get_key};
        get_value_s = '{i_lo_get_value, i_hi_get_value};
        if (srst) begin
            open          = '{0, 0};
            waiting       = '{0, 0};
            dn_active     = 0;
            dn_accepted   = 0;
            ack_pending   = 0;
            prev_req      = 0;
            reset_checked = 0;
            cycle         = 0;
        end else begin
            cycle++;
            if (!reset_checked) begin
                if (i_db_req !== 1'b0) report_mismatch("o_db_req", 0, i_db_req);
                if (i_hi_ack !== 1'b0) report_mismatch("o_hi_ack", 0, i_hi_ack);
                if (i_lo_ack !== 1'b0) report_mismatch("o_lo_ack", 0, i_lo_ack);
                if (i_hi_rdy !== 1'b1) report_mismatch("o_hi_rdy", 1, i_hi_rdy);
                if (i_lo_rdy !== 1'b1) report_mismatch("o_lo_rdy", 1, i_lo_rdy);
                reset_checked = 1;
            end
            for (int p = 0; p < 2; p++) begin
                if (open[p] && rdy_s[p])
                    report_problem($sformatf("rdy high on %s port while busy", port_name(p)));
            end

            // Controller acks, due one cycle after the peripheral ack
            for (int p = 0; p < 2; p++) begin
                if (ack_s[p]) begin
                    if (ack_pending && ack_owner == p && ack_due == cycle) begin
                        if (status_s[p] !== exp_status)
                            report_mismatch($sformatf("o_%s_status", port_name(p)),
                                            exp_status, status_s[p]);
                        if (get_valid_s[p] !== exp_get_valid)
                            report_mismatch($sformatf("o_%s_get_valid", port_name(p)),
                                            exp_get_valid, get_valid_s[p]);
                        if (get_key_s[p] !== exp_get_key)
                            report_mismatch($sformatf("o_%s_get_key", port_name(p)),
                                            exp_get_key, get_key_s[p]);
                        if (get_value_s[p] !== exp_get_value)
                            report_mismatch($sformatf("o_%s_get_value", port_name(p)),
                                            exp_get_value, get_value_s[p]);
                        open[p]     = 0;
                        ack_pending = 0;
                    end else begin
                        report_problem($sformatf("unexpected ack on %s port", port_name(p)));
                    end
                end
            end
            if (ack_pending && ack_due == cycle) begin
                report_problem($sformatf("missing ack on %s port", port_name(ack_owner)));
                open[ack_owner] = 0;
                ack_pending     = 0;
            end

            // Peripheral ack closes the downstream transaction
            if (i_db_ack) begin
                if (dn_accepted) begin
                    ack_pending   = 1;
                    ack_owner     = dn_owner;
                    ack_due       = cycle + 1;
                    exp_status    = (rec_key[dn_owner] == 8'hff) ? STATUS_ERROR : STATUS_OK;
                    exp_get_valid = (rec_cmd[dn_owner] == CMD_GET);
                    exp_get_key   = rec_key[dn_owner];
                    exp_get_value = rec_val[dn_owner] + db_value_t'(rec_key[dn_owner]);
                end else begin
                    report_problem("peripheral ack without an accepted request");
                end
                dn_active   = 0;
                dn_accepted = 0;
            end

            // New downstream request; hi wins if its proxy was pending
            if (i_db_req && !prev_req) begin
                if (dn_active)
                    report_problem("new downstream request before the previous ack");
                cand = -1;
                if (waiting[1] && acc_cyc[1] <= cycle - 2)
                    cand = 1;
                else if (waiting[0] && acc_cyc[0] <= cycle - 2)
                    cand = 0;
                if (cand < 0) begin
                    report_problem("downstream request with no controller request waiting");
                end else begin
                    dn_owner   = cand;
                    dn_active  = 1;
                    waiting[cand] = 0;
                    if (lone[cand] && cycle != acc_cyc[cand] + 2)
                        report_problem($sformatf("%s request reached o_db_req after %0d cycles",
                                                 port_name(cand), cycle - acc_cyc[cand]));
                end
            end
            // Fields must match the owner and stay stable while stalled
            if (i_db_req && dn_active && !dn_accepted) begin
                if (i_db_command !== rec_cmd[dn_owner])
                    report_mismatch("o_db_command", rec_cmd[dn_owner], i_db_command);
                if (i_db_key !== rec_key[dn_owner])
                    report_mismatch("o_db_key", rec_key[dn_owner], i_db_key);
                if (i_db_set_value !== rec_val[dn_owner])
                    report_mismatch("o_db_set_value", rec_val[dn_owner], i_db_set_value);
                if (i_db_rdy)
                    dn_accepted = 1;
            end

            // Controller acceptances
            for (int p = 0; p < 2; p++)
                acc_s[p] = req_s[p] && rdy_s[p];
            for (int p = 0; p < 2; p++) begin
                if (acc_s[p]) begin
                    if (open[p])
                        report_problem($sformatf("second request on busy %s port", port_name(p)));
                    lone[p]    = !open[1-p] && !acc_s[1-p];
                    open[p]    = 1;
                    waiting[p] = 1;
                    acc_cyc[p] = cycle;
                    rec_cmd[p] = cmd_s[p];
                    rec_key[p] = key_s[p];
                    rec_val[p] = val_s[p];
                end
            end
            prev_req = i_db_req;
        end
    end

endmodule : db_arb_checker

`default_nettype wire

//--- sim/tb_db_prio_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module tb_db_prio_arbiter
    import db_proto_pkg::*;
    import db_data_pkg::*;
();

    localparam int P_IDLE  = 0;
    localparam int P_STALL = 1;
    localparam int P_OFFER = 2;
    localparam int P_WAIT  = 3;
    localparam int P_ACK   = 4;

    logic        clk;
    logic        srst;
    logic        i_hi_req, i_lo_req;
    db_command_t i_hi_command, i_lo_command;
    db_key_t     i_hi_key, i_lo_key;
    db_value_t   i_hi_set_value, i_lo_set_value;
    logic        o_hi_rdy, o_hi_ack, o_hi_get_valid;
    logic        o_lo_rdy, o_lo_ack, o_lo_get_valid;
    db_status_t  o_hi_status, o_lo_status;
    db_key_t     o_hi_get_key, o_lo_get_key;
    db_value_t   o_hi_get_value, o_lo_get_value;
    logic        o_db_req;
    db_command_t o_db_command;
    db_key_t     o_db_key;
    db_value_t   o_db_set_value;
    logic        i_db_rdy, i_db_ack, i_db_get_valid;
    db_status_t  i_db_status;
    db_key_t     i_db_get_key;
    db_value_t   i_db_get_value;

    int          check_errors, protocol_errors, open_count;
    int          timeout_errors;
    int          cycle_cnt;
    int          seed;
    int          stall_cycles;

    // Transactions read from the data file
    bit          line_hi [$];
    int          line_start [$];
    logic [2:0]  line_cmd [$];
    db_key_t     line_key [$];
    db_value_t   line_val [$];

    // Peripheral model state
    int          pstate;
    int          stall_cnt;
    logic        per_srst_s, per_req_s;
    db_command_t per_cmd_s, rsp_cmd;
    db_key_t     per_key_s, rsp_key;
    db_value_t   per_val_s, rsp_val;

    db_prio_arbiter dut_i (.*);

    db_arb_checker checker_i (
        .clk(clk), .srst(srst),
        .i_hi_req(i_hi_req), .i_hi_command(i_hi_command), .i_hi_key(i_hi_key),
        .i_hi_set_value(i_hi_set_value), .i_hi_rdy(o_hi_rdy), .i_hi_ack(o_hi_ack),
        .i_hi_status(o_hi_status), .i_hi_get_valid(o_hi_get_valid),
        .i_hi_get_key(o_hi_get_key), .i_hi_get_value(o_hi_get_value),
        .i_lo_req(i_lo_req), .i_lo_command(i_lo_command), .i_lo_key(i_lo_key),
        .i_lo_set_value(i_lo_set_value), .i_lo_rdy(o_lo_rdy), .i_lo_ack(o_lo_ack),
        .i_lo_status(o_lo_status), .i_lo_get_valid(o_lo_get_valid),
        .i_lo_get_key(o_lo_get_key), .i_lo_get_value(o_lo_get_value),
        .i_db_req(o_db_req), .i_db_command(o_db_command), .i_db_key(o_db_key),
        .i_db_set_value(o_db_set_value), .i_db_rdy(i_db_rdy), .i_db_ack(i_db_ack),
        .o_check_errors(check_errors), .o_protocol_errors(protocol_errors),
        .o_open_count(open_count)
    );

    always #20 clk = !clk;

    always @(posedge clk) begin
        cycle_cnt <= srst ? 0 : cycle_cnt + 1;
    end

    // Peripheral model stalls rdy, then acks two cycles after acceptance
    always @(posedge clk) begin
        per_srst_s = srst;
        per_req_s  = o_db_req;
        per_cmd_s  = o_db_command;
        per_key_s  = o_db_key;
        per_val_s  = o_db_set_value;
        #2;
        if (per_srst_s) begin
            i_db_rdy = 1'b0;
            i_db_ack = 1'b0;
            pstate   = P_IDLE;
        end else begin
            case (pstate)
                P_IDLE: begin
                    if (per_req_s && stall_cycles == 0) begin
                        i_db_rdy = 1'b1;
                        pstate   = P_OFFER;
                    end else if (per_req_s) begin
                        stall_cnt = stall_cycles;
                        pstate    = P_STALL;
                    end
                end
                P_STALL: begin
                    stall_cnt--;
                    if (stall_cnt == 0) begin
                        i_db_rdy = 1'b1;
                        pstate   = P_OFFER;
                    end
                end
                P_OFFER: begin
                    rsp_cmd  = per_cmd_s;
                    rsp_key  = per_key_s;
                    rsp_val  = per_val_s;
                    i_db_rdy = 1'b0;
                    pstate   = P_WAIT;
                end
                P_WAIT: begin
                    i_db_ack       = 1'b1;
                    i_db_status    = (rsp_key == 8'hff) ? STATUS_ERROR : STATUS_OK;
                    i_db_get_valid = (rsp_cmd == CMD_GET);
                    i_db_get_key   = rsp_key;
                    i_db_get_value = rsp_val + db_value_t'(rsp_key);
                    pstate         = P_ACK;
                end
                default: begin
                    i_db_ack       = 1'b0;
                    i_db_get_valid = 1'b0;
                    pstate         = P_IDLE;
                end
            endcase
        end
    end

    task automatic next_slot();
        @(posedge clk);
        #2;
    endtask

    task automatic set_request(input bit is_hi, input logic req, input logic [2:0] cmd,
                               input db_key_t key, input db_value_t val);
        if (is_hi) begin
            i_hi_req       = req;
            i_hi_command   = db_command_t'(cmd);
            i_hi_key       = key;
            i_hi_set_value = val;
        end else begin
            i_lo_req       = req;
            i_lo_command   = db_command_t'(cmd);
            i_lo_key       = key;
            i_lo_set_value = val;
        end
    endtask

    // Drives one request and waits for its ack, starting and ending 2 ns after an edge
    task automatic run_txn(input bit is_hi, input logic [2:0] cmd, input db_key_t key,
                           input db_value_t val);
        int   waited;
        logic seen;
        string name;
        name   = is_hi ? "hi" : "lo";
        set_request(is_hi, 1'b1, cmd, key, val);
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < 200) begin
            @(posedge clk);
            seen = is_hi ? o_hi_rdy : o_lo_rdy;
            waited++;
        end
        #2;
        set_request(is_hi, 1'b0, cmd, key, val);
        if (!seen) begin
            $display("Timeout: %s port saw no rdy within 200 cycles", name);
            timeout_errors++;
            return;
        end
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < 200) begin
            @(posedge clk);
            seen = is_hi ? o_hi_ack : o_lo_ack;
            waited++;
        end
        #2;
        if (!seen) begin
            $display("Timeout: %s port got no ack within 200 cycles", name);
            timeout_errors++;
        end
    endtask

    task automatic run_port(input bit is_hi);
        int gap;
        int waited;
        for (int i = 0; i < line_hi.size(); i++) begin
            if (line_hi[i] == is_hi) begin
                if (line_start[i] == 0) begin
                    gap = $random(seed) & 3;
                    repeat (gap) next_slot();
                end else begin
                    waited = 0;
                    while (cycle_cnt < line_start[i] && waited < 1000) begin
                        next_slot();
                        waited++;
                    end
                    if (cycle_cnt < line_start[i]) begin
                        $display("Timeout: %s port never reached start cycle %0d",
                                 is_hi ? "hi" : "lo", line_start[i]);
                        timeout_errors++;
                    end
                end
                run_txn(is_hi, line_cmd[i], line_key[i], line_val[i]);
            end
        end
    endtask

    task automatic load_tests();
        int                fd;
        int                rc;
        reg [8*128-1:0]    text;
        reg [8*8-1:0]      tag;
        int                start;
        logic [2:0]        cmd;
        db_key_t           key;
        db_value_t         val;
        fd = $fopen("sim/db_arb_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            timeout_errors++;
            return;
        end
        while (!$feof(fd)) begin
            rc = $fgets(text, fd);
            if (rc != 0 && $sscanf(text, "%s %d %h %h %h", tag, start, cmd, key, val) == 5)
            begin
                if (tag == "stall") begin
                    stall_cycles = start;
                end else begin
                    line_hi.push_back(tag == "hi");
                    line_start.push_back(start);
                    line_cmd.push_back(cmd);
                    line_key.push_back(key);
                    line_val.push_back(val);
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        clk            = 1'b0;
        srst           = 1'b1;
        seed           = 95073;
        stall_cycles   = 0;
        timeout_errors = 0;
        i_db_rdy       = 1'b0;
        i_db_ack       = 1'b0;
        i_db_status    = STATUS_OK;
        i_db_get_valid = 1'b0;
        i_db_get_key   = '0;
        i_db_get_value = '0;
        set_request(1'b1, 1'b0, 3'd0, '0, '0);
        set_request(1'b0, 1'b0, 3'd0, '0, '0);
        load_tests();
        repeat (5) @(posedge clk);
        #2;
        srst = 1'b0;
        fork
            run_port(1'b1);
            run_port(1'b0);
        join
        repeat (5) next_slot();
        if (open_count != 0) begin
            $display("%0d transactions never completed", open_count);
            timeout_errors++;
        end
        $display("Errors: value checks %0d, protocol %0d, timeouts %0d",
                 check_errors, protocol_errors, timeout_errors);
        if (check_errors + protocol_errors + timeout_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : tb_db_prio_arbiter

`default_nettype wire

//--- sim/db_arb_tests.txt
# port start command key value
# start is a decimal cycle, 0 means after the previous line; command, key and value are hex
stall 3 0 0 0
hi 10 1 12 0000
lo 30 2 34 1234
hi 0 2 56 abcd
lo 0 1 34 0000
hi 0 1 ff 0000
# contention, both ports start together
hi 90 2 a0 1111
lo 90 3 77 2222
hi 0 4 00 0000
lo 0 1 ff 0003
hi 0 1 a0 0000
lo 0 2 0f fff0
# lo starts one cycle early and goes first
lo 160 1 21 0000
hi 161 2 22 5555
lo 0 3 23 0000
hi 0 1 22 0000
# second contention block
hi 220 1 31 0000
lo 220 2 32 8000
hi 0 2 33 7fff
lo 0 1 32 0000
lo 0 4 00 0000
hi 0 3 31 0000
hi 0 1 ff 00aa
lo 0 2 ff 00bb

//--- sim.f
+incdir+common
common/db_proto_pkg.sv
common/db_data_pkg.sv
logic/db_req_proxy.sv
arbiter/db_ctrl_mux.sv
arbiter/db_prio_arbiter.sv
sim/db_arb_checker.sv
sim/tb_db_prio_arbiter.sv

//--- Bender.yml
package:
  name: db_prio_arbiter

sources:
  - include_dirs:
      - common
    files:
      - common/db_proto_pkg.sv
      - common/db_data_pkg.sv
      - logic/db_req_proxy.sv
      - arbiter/db_ctrl_mux.sv
      - arbiter/db_prio_arbiter.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/db_arb_checker.sv
      - sim/tb_db_prio_arbiter.sv
